/* hw/freq_counter_pkg.sv */
`default_nettype none

package freq_counter_pkg;

    //////////////////////////////
    // Types
    //////////////////////////////

    // One decimal digit, values 0 to 9
    typedef logic [3:0] bcd_digit_t;

    // Gate timer cycle counter
    typedef logic [31:0] gate_count_t;

    // Window status from the gate timer
    typedef struct packed {
        logic open;   // High while a window is running
        logic close;  // One-cycle pulse on the last cycle of a window
    } gate_status_t;

    //////////////////////////////
    // Constants
    //////////////////////////////

    // Eight digits covers up to 99,999,999 per window
    localparam int num_digits_default = 8;

    // 100 ms at 100 MHz
    localparam gate_count_t gate_cycles_default = 32'd10_000_000;

    // Top value of a decade digit
    localparam bcd_digit_t digit_max = 4'd9;

endpackage

`default_nettype wire

/* hw/pulse_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_sync (
    input  wire  clk,
    input  wire  rst_n,
    input  logic en,
    input  logic pulse,
    output logic count_strobe
);

    //////////////////////////////
    // Synchronizer and history
    //////////////////////////////

    logic sync_meta;
    logic sync_level;
    logic level_hist;
    logic strobe_q;

    // The chain keeps sampling while en is low, so a level that is
    // already high when en rises has a high history and gives no edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta  <= 1'b0;
            sync_level <= 1'b0;
            level_hist <= 1'b0;
        end else begin
            sync_meta  <= pulse;
            sync_level <= sync_meta;
            level_hist <= sync_level;
        end
    end

    //////////////////////////////
    // Edge strobe
    //////////////////////////////

    // Registered strobe, three cycles after the first sample of the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_q <= 1'b0;
        end else if (!en) begin
            strobe_q <= 1'b0;
        end else begin
            // Rising edge of the synchronized level
            strobe_q <= sync_level & ~level_hist;
        end
    end

    assign count_strobe = strobe_q;

endmodule

`default_nettype wire

/* hw/gate_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module gate_timer #(
    parameter freq_counter_pkg::gate_count_t gate_cycles = freq_counter_pkg::gate_cycles_default
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  logic                           en,
    output freq_counter_pkg::gate_status_t gate
);

    // Terminal count of a window
    localparam freq_counter_pkg::gate_count_t last_count =
        gate_cycles - freq_counter_pkg::gate_count_t'(1);

    //////////////////////////////
    // Window counter
    //////////////////////////////

    freq_counter_pkg::gate_count_t cycle_cnt;
    logic                          open_q;
    logic                          at_last;

    assign at_last = (cycle_cnt == last_count);

    // open_q rises at the edge that first samples en high,
    // the count runs from the cycle after that
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            open_q    <= 1'b0;
        end else if (!en) begin
            cycle_cnt <= '0;
            open_q    <= 1'b0;
        end else begin
            open_q <= 1'b1;
            if (open_q) begin
                // Wrap so windows follow with no gap
                if (at_last) begin
                    cycle_cnt <= '0;
                end else begin
                    cycle_cnt <= cycle_cnt + freq_counter_pkg::gate_count_t'(1);
                end
            end
        end
    end

    //////////////////////////////
    // Status outputs
    //////////////////////////////

    always_comb begin
        gate.open  = open_q;
        gate.close = open_q & at_last;
    end

endmodule

`default_nettype wire

/* hw/bcd_accumulator.sv */
`timescale 1ns/1ns
`default_nettype none

module bcd_accumulator #(
    parameter int num_digits = freq_counter_pkg::num_digits_default
) (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  logic                                          count_strobe,
    input  freq_counter_pkg::gate_status_t                gate,
    output freq_counter_pkg::bcd_digit_t [num_digits-1:0] result_digits,
    output logic                                          result_overflow,
    output logic                                          result_valid
);

    //////////////////////////////
    // Decade chain state
    //////////////////////////////

    freq_counter_pkg::bcd_digit_t [num_digits-1:0] digits_q;
    freq_counter_pkg::bcd_digit_t [num_digits-1:0] digits_nxt;
    logic                                          overflow_q;
    logic                                          overflow_nxt;

    // carry[i] is the increment into digit i, carry[num_digits] leaves the top
    logic [num_digits:0]   carry;
    logic [num_digits-1:0] at_max;

    // Only strobes inside a window are counted
    assign carry[0] = count_strobe & gate.open;

    //////////////////////////////
    // Combinational carry chain
    //////////////////////////////

    // The whole chain settles in one cycle, so the value sampled on
    // close already includes a strobe arriving in that same cycle
    for (genvar g = 0; g < num_digits; g++) begin : gen_digit
        assign at_max[g]    = (digits_q[g] == freq_counter_pkg::digit_max);
        assign carry[g + 1] = carry[g] & at_max[g];

        always_comb begin
            if (!carry[g]) begin
                digits_nxt[g] = digits_q[g];
            end else if (at_max[g]) begin
                // 9 wraps to 0 and passes the carry up
                digits_nxt[g] = '0;
            end else begin
                digits_nxt[g] = digits_q[g] + freq_counter_pkg::bcd_digit_t'(1);
            end
        end
    end

    // Sticky for the rest of the window once the top digit wraps
    assign overflow_nxt = overflow_q | carry[num_digits];

    //////////////////////////////
    // Chain registers
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digits_q   <= '0;
            overflow_q <= 1'b0;
        end else if (!gate.open || gate.close) begin
            // Idle, or window ending: start the next one from zero
            digits_q   <= '0;
            overflow_q <= 1'b0;
        end else begin
            digits_q   <= digits_nxt;
            overflow_q <= overflow_nxt;
        end
    end

    //////////////////////////////
    // Result latch
    //////////////////////////////

    freq_counter_pkg::bcd_digit_t [num_digits-1:0] result_digits_q;
    logic                                          result_overflow_q;
    logic                                          result_valid_q;

    // Result holds until the next close; cleared while no window runs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_digits_q   <= '0;
            result_overflow_q <= 1'b0;
        end else if (!gate.open) begin
            result_digits_q   <= '0;
            result_overflow_q <= 1'b0;
        end else if (gate.close) begin
            // Next-state values so the last strobe is included
            result_digits_q   <= digits_nxt;
            result_overflow_q <= overflow_nxt;
        end
    end

    // One cycle after close
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid_q <= 1'b0;
        end else begin
            result_valid_q <= gate.close;
        end
    end

    assign result_digits   = result_digits_q;
    assign result_overflow = result_overflow_q;
    assign result_valid    = result_valid_q;

endmodule

`default_nettype wire

/* hw/freq_counter_top.sv */
`timescale 1ns/1ns
`default_nettype none

module freq_counter_top #(
    parameter int                            num_digits  = freq_counter_pkg::num_digits_default,
    parameter freq_counter_pkg::gate_count_t gate_cycles = freq_counter_pkg::gate_cycles_default
) (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  logic                                          en,
    input  logic                                          pulse,
    output freq_counter_pkg::bcd_digit_t [num_digits-1:0] result_digits,
    output logic                                          result_overflow,
    output logic                                          result_valid
);

    //////////////////////////////
    // Internal nets
    //////////////////////////////

    logic                           count_strobe;
    freq_counter_pkg::gate_status_t gate;

    //////////////////////////////
    // Producers
    //////////////////////////////

    // Async pulse in, one strobe per rising edge out
    pulse_sync pulse_sync_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .pulse        (pulse),
        .count_strobe (count_strobe)
    );

    // Back-to-back measurement windows
    gate_timer #(
        .gate_cycles (gate_cycles)
    ) gate_timer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .gate  (gate)
    );

    //////////////////////////////
    // Counter and result
    //////////////////////////////

    bcd_accumulator #(
        .num_digits (num_digits)
    ) bcd_accumulator_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .count_strobe    (count_strobe),
        .gate            (gate),
        .result_digits   (result_digits),
        .result_overflow (result_overflow),
        .result_valid    (result_valid)
    );

endmodule

`default_nettype wire

/* verification/freq_counter_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module freq_counter_tb;

    //////////////////////////////
    // Test constants
    //////////////////////////////

    localparam int num_digits = 2;
    localparam freq_counter_pkg::gate_count_t gate_cycles = 32'd400;
    localparam int window_len = 400;
    localparam int wait_limit = 3 * window_len;
    localparam int num_rows = 12;

    // Pulse driven at slot 5 gives a strobe in window cycle 8
    localparam int first_slot = 5;
    // Last strobe stays at least 8 cycles before the close cycle
    localparam int pulse_budget = 378;

    // One row of the stimulus table
    typedef struct packed {
        logic [7:0] count;
        logic [7:0] period;
        logic       drop_en;
    } window_row_t;

    //////////////////////////////
    // DUT and clock
    //////////////////////////////

    logic                                          clk;
    logic                                          rst_n;
    logic                                          en;
    logic                                          pulse;
    freq_counter_pkg::bcd_digit_t [num_digits-1:0] result_digits;
    logic                                          result_overflow;
    logic                                          result_valid;

    window_row_t rows [num_rows];
    logic [31:0] rng_state;
    int          cycle_count;
    int          slot;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          last_valid_cycle;
    logic        have_last_valid;
    logic        timed_out;

    freq_counter_top #(
        .num_digits  (num_digits),
        .gate_cycles (gate_cycles)
    ) dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .en              (en),
        .pulse           (pulse),
        .result_digits   (result_digits),
        .result_overflow (result_overflow),
        .result_valid    (result_valid)
    );

    always #4 clk = ~clk;

    // Free-running count of rising edges
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic window_row_t make_row(input int count, input int period,
                                             input logic drop_en);
        window_row_t row;
        row.count   = 8'(count);
        row.period  = 8'(period);
        row.drop_en = drop_en;
        return row;
    endfunction

    task automatic load_table();
        rows[0]  = make_row(0, 4, 1'b0);
        rows[1]  = make_row(1, 4, 1'b0);
        rows[2]  = make_row(9, 8, 1'b0);
        rows[3]  = make_row(10, 6, 1'b0);
        rows[4]  = make_row(37, 5, 1'b0);
        // Dense rows need a short period to fit in 400 cycles
        rows[5]  = make_row(99, 3, 1'b0);
        rows[6]  = make_row(100, 3, 1'b0);
        rows[7]  = make_row(143, 2, 1'b0);
        rows[8]  = make_row(5, 4, 1'b0);
        // En dropped mid-window, then a fresh start
        rows[9]  = make_row(20, 6, 1'b1);
        rows[10] = make_row(12, 5, 1'b0);
        rows[11] = make_row(3, 7, 1'b0);
    endtask

    task automatic check_digits(input string name,
                                input freq_counter_pkg::bcd_digit_t expected,
                                input freq_counter_pkg::bcd_digit_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    // Two-digit model, wraps at 100 and flags the wrap
    task automatic check_result(input int count);
        int                           wrapped;
        freq_counter_pkg::bcd_digit_t exp_ones;
        freq_counter_pkg::bcd_digit_t exp_tens;
        wrapped  = count % 100;
        exp_ones = freq_counter_pkg::bcd_digit_t'(wrapped % 10);
        exp_tens = freq_counter_pkg::bcd_digit_t'(wrapped / 10);
        check_digits("result_digits[0]", exp_ones, result_digits[0]);
        check_digits("result_digits[1]", exp_tens, result_digits[1]);
        check_flag("result_overflow", count >= 100, result_overflow);
    endtask

    task automatic advance_cycles(input int n);
        repeat (n) @(negedge clk);
        slot += n;
    endtask

    task automatic skip_to_slot(input int target);
        if (target > slot) begin
            advance_cycles(target - slot);
        end
    endtask

    // One-cycle high pulses with LCG jitter on the low time
    task automatic send_pulses(input int count, input int period);
        int slack;
        int gap;
        int i;
        skip_to_slot(first_slot);
        slack = 0;
        if (count > 0) begin
            slack = (pulse_budget - count * period) / count;
        end
        for (i = 0; i < count; i++) begin
            pulse = 1'b1;
            advance_cycles(1);
            pulse = 1'b0;
            rng_state = lcg_next(rng_state);
            gap = period - 1 + int'(rng_state[23:16]) % (slack + 1);
            advance_cycles(gap);
        end
    endtask

    // En goes high here, slot 0 is the first window cycle
    task automatic start_window();
        en = 1'b1;
        @(negedge clk);
        slot = 0;
        have_last_valid = 1'b0;
    endtask

    task automatic wait_for_result(output logic found);
        int waited;
        found  = 1'b0;
        waited = 0;
        while (!found && waited < wait_limit) begin
            @(negedge clk);
            waited++;
            if (result_valid === 1'b1) begin
                found = 1'b1;
            end
        end
        // Valid arrives in the first cycle of the next window
        slot = 0;
    endtask

    task automatic watch_no_result(input int cycles);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < cycles) begin
            @(negedge clk);
            waited++;
            if (result_valid !== 1'b0) begin
                check_flag("result_valid", 1'b0, result_valid);
                seen = 1'b1;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("Test %s: pass", name);
            tests_passed++;
        end else begin
            $display("Test %s: FAIL (%0d errors)", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        logic found;
        int   row_errors;
        int   idx;
        int   count;
        clk              = 1'b0;
        rst_n            = 1'b0;
        en               = 1'b0;
        pulse            = 1'b0;
        rng_state        = 32'd90;
        slot             = 0;
        errors           = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        last_valid_cycle = 0;
        have_last_valid  = 1'b0;
        timed_out        = 1'b0;
        load_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle with pulse held high, nothing may move
        row_errors = errors;
        pulse = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_digits("result_digits[0]", 4'h0, result_digits[0]);
            check_digits("result_digits[1]", 4'h0, result_digits[1]);
            check_flag("result_overflow", 1'b0, result_overflow);
            check_flag("result_valid", 1'b0, result_valid);
        end
        report_test("idle before enable", row_errors);

        // Pulse stays high across the rise of en
        start_window();
        advance_cycles(1);
        pulse = 1'b0;

        for (idx = 0; idx < num_rows && !timed_out; idx++) begin
            row_errors = errors;
            count = int'(rows[idx].count);
            send_pulses(count, int'(rows[idx].period));
            if (rows[idx].drop_en) begin
                en = 1'b0;
                watch_no_result(window_len + 100);
                start_window();
            end else begin
                wait_for_result(found);
                if (!found) begin
                    $display("Timeout: no result_valid within three windows in row %0d", idx);
                    errors++;
                    timed_out = 1'b1;
                end else begin
                    check_result(count);
                    if (have_last_valid && cycle_count - last_valid_cycle != window_len) begin
                        $display("Mismatch result_valid spacing: expected 0x%h, got 0x%h",
                                 window_len, cycle_count - last_valid_cycle);
                        errors++;
                    end
                    last_valid_cycle = cycle_count;
                    have_last_valid  = 1'b1;
                    // Valid lasts a single cycle
                    advance_cycles(1);
                    check_flag("result_valid", 1'b0, result_valid);
                end
            end
            report_test($sformatf("row %0d, %0d pulses", idx, count), row_errors);
        end

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* freq_counter.f */
hw/freq_counter_pkg.sv
hw/pulse_sync.sv
hw/gate_timer.sv
hw/bcd_accumulator.sv
hw/freq_counter_top.sv
verification/freq_counter_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f freq_counter.f --top-module freq_counter_tb \
    -Mdir obj_dir -o freq_counter_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/freq_counter_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
